// ==== hw/lpc_snoop_params.svh ====
// lpc snooper field widths, nibble counts and the post port address.
`ifndef LPC_SNOOP_PARAMS_SVH
`define LPC_SNOOP_PARAMS_SVH

// address and data field widths.
`define LPC_ADDR_W 32
`define LPC_DATA_W 8

// address nibbles per cycle kind.
`define LPC_IO_NIBBLES 4
`define LPC_MEM_NIBBLES 8

// turnaround length in clocks.
`define LPC_TAR_CLOCKS 2

// cycle and abort counters wrap at this width.
`define LPC_COUNT_W 16

`define LPC_POST_PORT 16'h0080 // bios post code port.

`endif

// ==== hw/lpc_snoop_pkg.sv ====
// lpc snooper types shared by the decoder, collector and reporter.
`default_nettype none
`include "lpc_snoop_params.svh"

package lpc_snoop_pkg;

	// **************************************************************************
	// decoder states
	// **************************************************************************

	typedef enum logic [3:0] {
		st_idle    = 4'd0, // bus idle.
		st_start   = 4'd1, // start field, last nibble not ours.
		st_cyctype = 4'd2, // start 0000 seen, cycle type next.
		st_addr    = 4'd3,
		st_tar_in  = 4'd4, // host to peripheral turnaround.
		st_sync    = 4'd5,
		st_data    = 4'd6,
		st_tar_out = 4'd7  // peripheral to host turnaround.
	} lpc_state_e;

	// **************************************************************************
	// field events from decode to collect
	// **************************************************************************

	typedef enum logic [2:0] {
		fe_none     = 3'd0,
		fe_cyctype  = 3'd1,
		fe_addr     = 3'd2,
		fe_data     = 3'd3,
		fe_done_ok  = 3'd4,
		fe_done_err = 3'd5, // sync 1010 seen.
		fe_abort    = 3'd6
	} lpc_field_e;

	// cycle kind, lpc_ad[3:1] with bit 3 clear.
	typedef enum logic [1:0] {
		cyc_io_read   = 2'b00,
		cyc_io_write  = 2'b01,
		cyc_mem_read  = 2'b10,
		cyc_mem_write = 2'b11
	} lpc_cycle_e;

	typedef struct packed {
		lpc_field_e kind;
		logic [3:0] nibble; // lpc_ad as sampled.
	} lpc_field_t;

	// one finished cycle.
	typedef struct packed {
		lpc_cycle_e              kind;
		logic [`LPC_ADDR_W-1:0] addr;  // upper half zero for i/o.
		logic [`LPC_DATA_W-1:0] data;
		logic                    error; // sync error.
	} lpc_cycle_t;

endpackage

`default_nettype wire

// ==== hw/lpc_frame_decode.sv ====
// lpc frame decoder: follows the bus phases and tags each nibble with a field event.
`timescale 1ns/1ps
`default_nettype none
`include "lpc_snoop_params.svh"

module lpc_frame_decode (
	input  wire                       lpc_clock,
	input  wire                       lpc_reset, // async, active low.
	input  wire  [3:0]                lpc_ad,
	input  wire                       lpc_frame, // active low.
	output lpc_snoop_pkg::lpc_field_t field
);

	localparam int cnt_w = $clog2(`LPC_MEM_NIBBLES);
	localparam int data_nibbles = `LPC_DATA_W / 4;

	localparam logic [3:0] ad_start        = 4'b0000;
	localparam logic [3:0] ad_abort        = 4'b1111;
	localparam logic [3:0] sync_ready      = 4'b0000;
	localparam logic [3:0] sync_short_wait = 4'b0101;
	localparam logic [3:0] sync_long_wait  = 4'b0110;
	localparam logic [3:0] sync_error      = 4'b1010;

	lpc_snoop_pkg::lpc_state_e state;
	lpc_snoop_pkg::lpc_cycle_e cyc_type; // kind of the cycle in progress.
	logic [cnt_w-1:0] count; // nibbles left in the field.
	logic sync_err;
	logic abort_held; // abort pattern seen on the last clock.
	logic abort_hit;
	logic is_write;

	assign abort_hit = !lpc_frame && (lpc_ad == ad_abort);
	assign is_write = cyc_type[0]; // direction bit of the cycle type.

	// **************************************************************************
	// field state machine
	// **************************************************************************

	always_ff @(posedge lpc_clock or negedge lpc_reset) begin
		if (!lpc_reset) begin
			state <= lpc_snoop_pkg::st_idle;
			count <= '0;
			sync_err <= 1'b0;
			abort_held <= 1'b0;
			field <= '0;
		end else begin
			abort_held <= abort_hit;
			field.kind <= lpc_snoop_pkg::fe_none; // default, no event.
			field.nibble <= lpc_ad;
			if (abort_hit) begin
				// master abort wins in any state. one event per abort.
				state <= lpc_snoop_pkg::st_idle;
				count <= '0;
				if (!abort_held)
					field.kind <= lpc_snoop_pkg::fe_abort;
			end else begin
				case (state)
					lpc_snoop_pkg::st_idle: begin
						if (!lpc_frame)
							state <= (lpc_ad == ad_start) ? lpc_snoop_pkg::st_cyctype
								: lpc_snoop_pkg::st_start;
					end
					lpc_snoop_pkg::st_start: begin
						if (!lpc_frame) begin
							if (lpc_ad == ad_start)
								state <= lpc_snoop_pkg::st_cyctype;
						end else
							state <= lpc_snoop_pkg::st_idle; // someone else's cycle.
					end
					lpc_snoop_pkg::st_cyctype: begin
						if (!lpc_frame) begin
							// start held. only the last nibble counts.
							if (lpc_ad != ad_start)
								state <= lpc_snoop_pkg::st_start;
						end else if (!lpc_ad[3]) begin // i/o or memory.
							field.kind <= lpc_snoop_pkg::fe_cyctype;
							state <= lpc_snoop_pkg::st_addr;
							count <= lpc_ad[2] ? cnt_w'(`LPC_MEM_NIBBLES - 1)
								: cnt_w'(`LPC_IO_NIBBLES - 1);
						end else
							state <= lpc_snoop_pkg::st_idle; // dma or reserved.
					end
					lpc_snoop_pkg::st_addr: begin
						field.kind <= lpc_snoop_pkg::fe_addr;
						if (count != '0)
							count <= count - 1'b1;
						else if (is_write) begin
							state <= lpc_snoop_pkg::st_data; // host sends data first.
							count <= cnt_w'(data_nibbles - 1);
						end else begin
							state <= lpc_snoop_pkg::st_tar_in;
							count <= cnt_w'(`LPC_TAR_CLOCKS - 1);
						end
					end
					lpc_snoop_pkg::st_tar_in: begin
						if (count != '0)
							count <= count - 1'b1;
						else
							state <= lpc_snoop_pkg::st_sync;
					end
					lpc_snoop_pkg::st_sync: begin
						case (lpc_ad)
							sync_ready: begin
								sync_err <= 1'b0;
								if (is_write) begin
									state <= lpc_snoop_pkg::st_tar_out;
									count <= cnt_w'(`LPC_TAR_CLOCKS - 1);
								end else begin
									state <= lpc_snoop_pkg::st_data; // read data follows.
									count <= cnt_w'(data_nibbles - 1);
								end
							end
							sync_error: begin
								sync_err <= 1'b1; // no data after an error.
								state <= lpc_snoop_pkg::st_tar_out;
								count <= cnt_w'(`LPC_TAR_CLOCKS - 1);
							end
							sync_short_wait, sync_long_wait: ; // peripheral busy.
							default: state <= lpc_snoop_pkg::st_idle; // no valid sync.
						endcase
					end
					lpc_snoop_pkg::st_data: begin
						field.kind <= lpc_snoop_pkg::fe_data;
						if (count != '0)
							count <= count - 1'b1;
						else begin
							state <= is_write ? lpc_snoop_pkg::st_tar_in
								: lpc_snoop_pkg::st_tar_out;
							count <= cnt_w'(`LPC_TAR_CLOCKS - 1);
						end
					end
					lpc_snoop_pkg::st_tar_out: begin
						// done goes out on the first turnaround clock.
						if (count == cnt_w'(`LPC_TAR_CLOCKS - 1))
							field.kind <= sync_err ? lpc_snoop_pkg::fe_done_err
								: lpc_snoop_pkg::fe_done_ok;
						if (count != '0)
							count <= count - 1'b1;
						else
							state <= lpc_snoop_pkg::st_idle;
					end
					default: state <= lpc_snoop_pkg::st_idle;
				endcase
			end
		end
	end

	// cycle type kept for address length and field order.
	always_ff @(posedge lpc_clock) begin
		if (state == lpc_snoop_pkg::st_cyctype && lpc_frame)
			cyc_type <= lpc_snoop_pkg::lpc_cycle_e'(lpc_ad[2:1]);
	end

endmodule

`default_nettype wire

// ==== hw/lpc_field_collect.sv ====
// lpc field collector: assembles type, address and data events into a cycle record.
`timescale 1ns/1ps
`default_nettype none
`include "lpc_snoop_params.svh"

module lpc_field_collect (
	input  wire                            lpc_clock,
	input  wire                            lpc_reset,
	input  wire lpc_snoop_pkg::lpc_field_t field,
	output lpc_snoop_pkg::lpc_cycle_t      record,
	output logic                           record_done,
	output logic                           aborted
);

	// **************************************************************************
	// completion pulses
	// **************************************************************************

	always_ff @(posedge lpc_clock or negedge lpc_reset) begin
		if (!lpc_reset) begin
			record_done <= 1'b0;
			aborted <= 1'b0;
		end else begin
			record_done <= (field.kind == lpc_snoop_pkg::fe_done_ok)
				|| (field.kind == lpc_snoop_pkg::fe_done_err);
			aborted <= (field.kind == lpc_snoop_pkg::fe_abort);
		end
	end

	// **************************************************************************
	// record assembly
	// **************************************************************************

	always_ff @(posedge lpc_clock) begin
		case (field.kind)
			lpc_snoop_pkg::fe_cyctype: begin
				// new cycle. start from a clean record.
				record <= '{
					kind:  lpc_snoop_pkg::lpc_cycle_e'(field.nibble[2:1]),
					addr:  '0,
					data:  '0,
					error: 1'b0
				};
			end
			lpc_snoop_pkg::fe_addr: begin
				// msb nibble first, shifted in at the bottom.
				record.addr <= {record.addr[`LPC_ADDR_W-5:0], field.nibble};
			end
			lpc_snoop_pkg::fe_data: begin
				// low nibble first, shifted in at the top.
				record.data <= {field.nibble, record.data[`LPC_DATA_W-1:4]};
			end
			lpc_snoop_pkg::fe_done_err: record.error <= 1'b1;
			lpc_snoop_pkg::fe_abort: record <= '0; // partial record dropped.
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/lpc_cycle_report.sv ====
// lpc cycle reporter: publishes finished cycles and keeps the counters and post code.
`timescale 1ns/1ps
`default_nettype none
`include "lpc_snoop_params.svh"

module lpc_cycle_report (
	input  wire                             lpc_clock,
	input  wire                             lpc_reset,
	input  wire lpc_snoop_pkg::lpc_cycle_t  record,
	input  wire                             record_done,
	input  wire                             aborted,
	output lpc_snoop_pkg::lpc_cycle_t       cycle,
	output logic                            cycle_valid,
	output logic [`LPC_COUNT_W-1:0]         cycle_count,
	output logic [`LPC_COUNT_W-1:0]         abort_count,
	output logic [`LPC_DATA_W-1:0]          post_code
);

	logic post_hit;

	// clean i/o write to the post port.
	assign post_hit = (record.kind == lpc_snoop_pkg::cyc_io_write) && !record.error
		&& (record.addr == `LPC_ADDR_W'(`LPC_POST_PORT));

	always_ff @(posedge lpc_clock or negedge lpc_reset) begin
		if (!lpc_reset) begin
			cycle_valid <= 1'b0;
			cycle_count <= '0;
			abort_count <= '0;
			post_code <= '0;
		end else begin
			cycle_valid <= record_done; // one clock per cycle.
			if (record_done)
				cycle_count <= cycle_count + 1'b1; // wraps.
			if (aborted)
				abort_count <= abort_count + 1'b1;
			if (record_done && post_hit)
				post_code <= record.data;
		end
	end

	// record held until the next finished cycle.
	always_ff @(posedge lpc_clock) begin
		if (record_done)
			cycle <= record;
	end

endmodule

`default_nettype wire

// ==== hw/lpc_snoop.sv ====
// lpc snooper top: passive decode of i/o and memory cycles into reported records.
`timescale 1ns/1ps
`default_nettype none
`include "lpc_snoop_params.svh"

module lpc_snoop (
	input  wire                            lpc_clock,
	input  wire                            lpc_reset, // async, active low.
	input  wire [3:0]                      lpc_ad,
	input  wire                            lpc_frame,
	output wire lpc_snoop_pkg::lpc_cycle_t cycle,
	output wire                            cycle_valid,
	output wire [`LPC_COUNT_W-1:0]         cycle_count,
	output wire [`LPC_COUNT_W-1:0]         abort_count,
	output wire [`LPC_DATA_W-1:0]          post_code
);

	lpc_snoop_pkg::lpc_field_t field; // decode to collect.
	lpc_snoop_pkg::lpc_cycle_t record; // collect to report.
	logic record_done;
	logic aborted;

	lpc_frame_decode u_decode (
		.lpc_clock (lpc_clock),
		.lpc_reset (lpc_reset),
		.lpc_ad    (lpc_ad),
		.lpc_frame (lpc_frame),
		.field     (field)
	);

	lpc_field_collect u_collect (
		.lpc_clock   (lpc_clock),
		.lpc_reset   (lpc_reset),
		.field       (field),
		.record      (record),
		.record_done (record_done),
		.aborted     (aborted)
	);

	lpc_cycle_report u_report (
		.lpc_clock   (lpc_clock),
		.lpc_reset   (lpc_reset),
		.record      (record),
		.record_done (record_done),
		.aborted     (aborted),
		.cycle       (cycle),
		.cycle_valid (cycle_valid),
		.cycle_count (cycle_count),
		.abort_count (abort_count),
		.post_code   (post_code)
	);

endmodule

`default_nettype wire

// ==== verif/lpc_clock_gen.sv ====
// lpc testbench clock and reset: 8 ns clock, reset held low for the first 8 cycles.
`timescale 1ns/1ps
`default_nettype none

module lpc_clock_gen (
	output logic lpc_clock,
	output logic lpc_reset // active low.
);

	localparam int half_period = 4; // 8 ns period.

	initial begin
		lpc_clock = 1'b0;
		forever #(half_period) lpc_clock = ~lpc_clock;
	end

	initial begin
		lpc_reset = 1'b0;
		repeat (8) @(posedge lpc_clock);
		@(negedge lpc_clock); // release away from the sampling edge.
		lpc_reset = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/lpc_snoop_tb.sv ====
// lpc snooper testbench with directed lpc cycles and a check of every reported record.
`timescale 1ns/1ps
`default_nettype none
`include "lpc_snoop_params.svh"

module lpc_snoop_tb;

	localparam int report_wait = 64; // clocks allowed per report.
	localparam int run_limit = 2000; // run takes about 350 clocks.

	logic lpc_clock;
	logic lpc_reset;
	logic [3:0] lpc_ad;
	logic lpc_frame;
	lpc_snoop_pkg::lpc_cycle_t cycle;
	logic cycle_valid;
	logic [`LPC_COUNT_W-1:0] cycle_count;
	logic [`LPC_COUNT_W-1:0] abort_count;
	logic [`LPC_DATA_W-1:0] post_code;
	lpc_snoop_pkg::lpc_cycle_t seen_q[$]; // reports in arrival order.
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int clocks = 0;
	int seed;

	lpc_clock_gen clock_gen (.lpc_clock(lpc_clock), .lpc_reset(lpc_reset));

	lpc_snoop dut (
		.lpc_clock   (lpc_clock),
		.lpc_reset   (lpc_reset),
		.lpc_ad      (lpc_ad),
		.lpc_frame   (lpc_frame),
		.cycle       (cycle),
		.cycle_valid (cycle_valid),
		.cycle_count (cycle_count),
		.abort_count (abort_count),
		.post_code   (post_code)
	);

	// **************************************************************************
	// report monitor and run limit
	// **************************************************************************

	always @(negedge lpc_clock) begin
		if (cycle_valid)
			seen_q.push_back(cycle); // outputs settled half a clock ago.
	end

	always @(posedge lpc_clock) begin
		clocks = clocks + 1;
		if (clocks >= run_limit) begin
			$display("run stopped: tests still busy after %0d clocks", clocks);
			$display("Something failed");
			$finish;
		end
	end

	// **************************************************************************
	// bus driving
	// **************************************************************************

	task automatic drive(input logic frame, input logic [3:0] ad);
		@(negedge lpc_clock);
		lpc_frame = frame;
		lpc_ad = ad;
	endtask

	task automatic idle_clocks(input int n);
		repeat (n) drive(1'b1, 4'b1111);
	endtask

	// one full cycle from start to the last turnaround. waits are random short or long.
	task automatic drive_cycle(input lpc_snoop_pkg::lpc_cycle_e kind, input logic [31:0] addr,
		input logic [7:0] data, input int waits, input logic [3:0] last_sync);
		logic mem;
		logic wr;
		int i;
		mem = (kind == lpc_snoop_pkg::cyc_mem_read) || (kind == lpc_snoop_pkg::cyc_mem_write);
		wr = (kind == lpc_snoop_pkg::cyc_io_write) || (kind == lpc_snoop_pkg::cyc_mem_write);
		drive(1'b0, 4'b0000);
		drive(1'b1, {1'b0, mem, wr, 1'b0}); // type in bits 3:2 and direction in bit 1.
		for (i = (mem ? 7 : 3); i >= 0; i--)
			drive(1'b1, addr[4*i +: 4]); // msb nibble first.
		if (wr) begin
			drive(1'b1, data[3:0]);
			drive(1'b1, data[7:4]);
		end
		idle_clocks(2); // turnaround to peripheral.
		repeat (waits) drive(1'b1, ($urandom % 2) ? 4'b0101 : 4'b0110);
		drive(1'b1, last_sync);
		if (!wr && last_sync == 4'b0000) begin
			drive(1'b1, data[3:0]);
			drive(1'b1, data[7:4]);
		end
		idle_clocks(2); // turnaround back to host.
	endtask

	// **************************************************************************
	// checking helpers
	// **************************************************************************

	function automatic lpc_snoop_pkg::lpc_cycle_t make_record(
		input lpc_snoop_pkg::lpc_cycle_e kind, input logic [31:0] addr,
		input logic [7:0] data, input logic error);
		lpc_snoop_pkg::lpc_cycle_t rec;
		rec.kind = kind;
		rec.addr = (kind == lpc_snoop_pkg::cyc_io_read || kind == lpc_snoop_pkg::cyc_io_write)
			? {16'h0000, addr[15:0]} : addr;
		rec.data = data;
		rec.error = error;
		return rec;
	endfunction

	task automatic check_report(input lpc_snoop_pkg::lpc_cycle_t exp, input string where);
		lpc_snoop_pkg::lpc_cycle_t got;
		int n;
		n = 0;
		while (seen_q.size() == 0 && n < report_wait) begin
			@(posedge lpc_clock);
			n++;
		end
		if (seen_q.size() == 0) begin
			$display("%0t: %s got no cycle report within %0d clocks", $time, where, report_wait);
			errors++;
		end else begin
			got = seen_q.pop_front();
			if (got !== exp) begin
				$display("mismatch at %0t: %s record %h, expected %h", $time, where, got, exp);
				errors++;
			end
		end
	endtask

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic expect_quiet(input string where);
		idle_clocks(8);
		if (seen_q.size() != 0) begin
			$display("%0t: %s reported a cycle that should be ignored", $time, where);
			errors++;
			seen_q.delete();
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s: pass", name);
		else begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - errors_before);
		end
	endtask

	// **************************************************************************
	// directed tests
	// **************************************************************************

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_value("cycle_valid", {15'h0, cycle_valid}, 16'h0);
		check_value("cycle_count", cycle_count, 16'h0);
		check_value("abort_count", abort_count, 16'h0);
		check_value("post_code", {8'h0, post_code}, 16'h0);
		end_test("reset", e0);
	endtask

	task automatic test_post_write();
		int e0;
		logic [7:0] code;
		logic [15:0] port;
		e0 = errors;
		code = 8'($urandom);
		if (code == 8'h00)
			code = 8'h3c; // differs from the reset value.
		drive_cycle(lpc_snoop_pkg::cyc_io_write, 32'h0080, code, 0, 4'b0000);
		check_report(make_record(lpc_snoop_pkg::cyc_io_write, 32'h0080, code, 1'b0), "post");
		check_value("post_code", {8'h0, post_code}, {8'h0, code});
		port = 16'($urandom);
		if (port == 16'h0080)
			port = 16'h0081; // other port.
		drive_cycle(lpc_snoop_pkg::cyc_io_write, {16'h0, port}, ~code, 1, 4'b0000);
		check_report(make_record(lpc_snoop_pkg::cyc_io_write, {16'h0, port}, ~code, 1'b0), "port");
		check_value("post_code kept", {8'h0, post_code}, {8'h0, code});
		end_test("post_write", e0);
	endtask

	task automatic test_mem_read();
		int e0;
		int w;
		logic [31:0] addr;
		logic [7:0] data;
		logic [15:0] c0;
		e0 = errors;
		for (w = 0; w <= 5; w++) begin
			addr = $urandom;
			data = 8'($urandom);
			c0 = cycle_count;
			drive_cycle(lpc_snoop_pkg::cyc_mem_read, addr, data, w, 4'b0000);
			check_report(make_record(lpc_snoop_pkg::cyc_mem_read, addr, data, 1'b0), "mem read");
			check_value("cycle_count", cycle_count, c0 + 16'd1);
		end
		end_test("mem_read", e0);
	endtask

	task automatic test_abort();
		int e0;
		int n;
		logic [15:0] a0;
		logic [15:0] c0;
		logic [15:0] port;
		e0 = errors;
		a0 = abort_count;
		c0 = cycle_count;
		drive(1'b0, 4'b0000);
		drive(1'b1, 4'b0110); // memory write.
		drive(1'b1, 4'h1);
		drive(1'b1, 4'h2);
		drive(1'b1, 4'h3);
		repeat (4) drive(1'b0, 4'b1111); // master abort mid address.
		n = 0;
		while (abort_count == a0 && n < report_wait) begin
			@(negedge lpc_clock);
			n++;
		end
		expect_quiet("abort");
		check_value("abort_count", abort_count, a0 + 16'd1); // one count per abort run.
		check_value("cycle_count after abort", cycle_count, c0);
		port = 16'($urandom);
		drive_cycle(lpc_snoop_pkg::cyc_io_write, {16'h0, port}, 8'h5a, 0, 4'b0000);
		check_report(make_record(lpc_snoop_pkg::cyc_io_write, {16'h0, port}, 8'h5a, 1'b0),
			"after abort");
		end_test("abort", e0);
	endtask

	task automatic test_sync_error();
		int e0;
		logic [15:0] port;
		e0 = errors;
		port = 16'($urandom);
		drive_cycle(lpc_snoop_pkg::cyc_io_read, {16'h0, port}, 8'hff, 2, 4'b1010);
		// no data phase so the byte stays clear.
		check_report(make_record(lpc_snoop_pkg::cyc_io_read, {16'h0, port}, 8'h00, 1'b1),
			"sync error");
		end_test("sync_error", e0);
	endtask

	task automatic test_start_and_dma();
		int e0;
		logic [15:0] a0;
		logic [15:0] c0;
		logic [7:0] p0;
		e0 = errors;
		drive(1'b0, 4'b0010);
		drive(1'b0, 4'b0011); // drive_cycle adds the final 0000.
		drive_cycle(lpc_snoop_pkg::cyc_io_write, 32'h0000_0378, 8'ha5, 0, 4'b0000);
		check_report(make_record(lpc_snoop_pkg::cyc_io_write, 32'h0378, 8'ha5, 1'b0), "held");
		a0 = abort_count;
		c0 = cycle_count;
		p0 = post_code;
		drive(1'b0, 4'b0000);
		drive(1'b1, 4'b1000); // dma read.
		drive(1'b1, 4'b0001);
		drive(1'b1, 4'b0000);
		idle_clocks(2);
		drive(1'b0, 4'b0011); // foreign start then a post write body.
		drive(1'b1, 4'b0010);
		drive(1'b1, 4'h0);
		drive(1'b1, 4'h0);
		drive(1'b1, 4'h8);
		drive(1'b1, 4'h0);
		drive(1'b1, ~p0[3:0]);
		drive(1'b1, ~p0[7:4]);
		idle_clocks(2);
		drive(1'b1, 4'b0000);
		expect_quiet("dma and foreign start");
		check_value("cycle_count", cycle_count, c0);
		check_value("abort_count", abort_count, a0);
		check_value("post_code", {8'h0, post_code}, {8'h0, p0});
		end_test("start_and_dma", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		int i;
		logic [31:0] addr;
		logic [7:0] data;
		logic [15:0] c0;
		lpc_snoop_pkg::lpc_cycle_t exp[3];
		e0 = errors;
		c0 = cycle_count;
		for (i = 0; i < 3; i++) begin
			addr = $urandom;
			data = 8'($urandom);
			exp[i] = make_record(lpc_snoop_pkg::cyc_mem_write, addr, data, 1'b0);
			drive_cycle(lpc_snoop_pkg::cyc_mem_write, addr, data, i, 4'b0000);
		end
		for (i = 0; i < 3; i++)
			check_report(exp[i], "back to back");
		check_value("cycle_count", cycle_count, c0 + 16'd3);
		end_test("back_to_back", e0);
	endtask

	initial begin
		seed = $urandom(32'h1a4b_1cd4);
		lpc_frame = 1'b1;
		lpc_ad = 4'b1111;
		@(posedge lpc_reset);
		idle_clocks(4);
		test_reset();
		test_post_write();
		test_mem_read();
		test_abort();
		test_sync_error();
		test_start_and_dma();
		test_back_to_back();
		idle_clocks(4);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/lpc_snoop_pkg.sv
hw/lpc_frame_decode.sv
hw/lpc_field_collect.sv
hw/lpc_cycle_report.sv
hw/lpc_snoop.sv
verif/lpc_clock_gen.sv
verif/lpc_snoop_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lpc snooper testbench with verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module lpc_snoop_tb \
	-f src.f -o lpc_snoop_sim
./obj_dir/lpc_snoop_sim > sim.log 2>&1
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi
